//--- tb.f
+incdir+include
verilog/soc_pkg.sv
verilog/wb_addr_decoder.sv
verilog/wb_sram.sv
verilog/wb_timer.sv
verilog/soc_top.sv
verif/tb_soc.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bus system testbench with Verilator.
# Exit status is 0 on pass and 1 on any failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_soc
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_soc -f tb.f \
   --Mdir "$BUILD_DIR" -o "$SIM_BIN"
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi
if [ "$run_status" -ne 0 ]; then
   echo "Simulator exited with status $run_status"
   exit 1
fi

echo "Simulation passed"
exit 0

//--- include/tb_soc_tasks.svh
////////////////////////////////////////////////////////////
// Bus master tasks, value check and memory model
////////////////////////////////////////////////////////////
`ifndef TB_SOC_TASKS_SVH
`define TB_SOC_TASKS_SVH

logic [31:0] mem_model [MEM_WORDS];                  // Expected memory contents

// Reason line, then stop
task automatic abort_run(input string why);
   $display("%s", why);
   $display("Test FAILED");
   $fatal(1);
endtask

task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
   if (act !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%h, expected 0x%h", name, act, exp));
   end
endtask

// Lanes without a select bit keep their old byte
function automatic logic [31:0] merge_bytes(input logic [31:0] old_d,
                                            input logic [31:0] new_d,
                                            input logic [3:0]  sel);
   logic [31:0] lane_mask;
   lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   return (old_d & ~lane_mask) | (new_d & lane_mask);
endfunction

// Start pattern, every index bit matters
function automatic logic [31:0] fill_word(input int idx);
   return (32'(idx) * 32'h0001_0003) ^ 32'h5A3C_96E1;
endfunction

function automatic logic in_window(input logic [31:0] adr);
   return ((adr & soc_pkg::SRAM_MASK_DEF) == (soc_pkg::SRAM_BASE_DEF & soc_pkg::SRAM_MASK_DEF))
       || ((adr & soc_pkg::TIMER_MASK_DEF) == (soc_pkg::TIMER_BASE_DEF & soc_pkg::TIMER_MASK_DEF));
endfunction

// One classic cycle, entered DRV_DLY after a rising edge
task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                          input logic [3:0] sel, output logic [31:0] rdat, output logic err);
   int waits;
   wb_cyc_i = 1'b1;
   wb_stb_i = 1'b1;
   wb_we_i  = we;
   wb_adr_i = adr;
   wb_dat_i = wdat;
   wb_sel_i = sel;
   waits    = 0;
   do begin
      @(posedge hclk_i);
      #DRV_DLY;
      waits++;
   end while (!wb_ack_o && !wb_err_o && waits < 4);
   if (!wb_ack_o && !wb_err_o) begin
      abort_run($sformatf("No acknowledge within 4 cycles for the access to 0x%h", adr));
   end
   check_value("response latency", 32'(waits), 32'd1);
   check_value("wb_ack_o & wb_err_o", wb_ack_o & wb_err_o, 1'b0);
   rdat     = wb_dat_o;                              // Valid while ack is high
   err      = wb_err_o;
   wb_cyc_i = 1'b0;
   wb_stb_i = 1'b0;
   wb_we_i  = 1'b0;
   @(posedge hclk_i);                                // Idle cycle between requests
   #DRV_DLY;
   check_value("wb_ack_o", wb_ack_o, 1'b0);          // One cycle response only
   check_value("wb_err_o", wb_err_o, 1'b0);
endtask

task automatic mem_write(input int idx, input logic [31:0] d, input logic [3:0] sel);
   logic [31:0] rd;
   logic        err;
   bus_access(1'b1, soc_pkg::SRAM_BASE_DEF + 32'(idx * 4), d, sel, rd, err);
   check_value("wb_err_o", err, 1'b0);
   mem_model[idx] = merge_bytes(mem_model[idx], d, sel);
endtask

task automatic mem_check(input int idx);
   logic [31:0] rd;
   logic        err;
   bus_access(1'b0, soc_pkg::SRAM_BASE_DEF + 32'(idx * 4), 32'd0, 4'hF, rd, err);
   check_value("wb_err_o", err, 1'b0);
   check_value($sformatf("wb_dat_o mem[%0d]", idx), rd, mem_model[idx]);
endtask

task automatic timer_write(input logic [3:0] ofs, input logic [31:0] d);
   logic [31:0] rd;
   logic        err;
   bus_access(1'b1, soc_pkg::TIMER_BASE_DEF + {26'd0, ofs, 2'b00}, d, 4'hF, rd, err);
   check_value("wb_err_o", err, 1'b0);
endtask

task automatic timer_read(input logic [3:0] ofs, output logic [31:0] d);
   logic err;
   bus_access(1'b0, soc_pkg::TIMER_BASE_DEF + {26'd0, ofs, 2'b00}, 32'd0, 4'hF, d, err);
   check_value("wb_err_o", err, 1'b0);
endtask

`endif

//--- verif/tb_soc.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Testbench for the Wishbone bus system top level
// Random memory traffic, unmapped accesses and timer runs
////////////////////////////////////////////////////////////
module tb_soc;

   localparam int MEM_WORDS      = 512;     // Memory depth under test
   localparam int DRV_DLY        = 1;       // Input change after the rising edge, ns
   localparam int N_RAND         = 240;     // Random memory accesses
   localparam int N_MISS         = 30;      // Unmapped accesses
   // About 2,000 cycles of traffic and timer waits, run stops at ten times that
   localparam int TIMEOUT_CYCLES = 20000;

   logic        hclk_i;
   logic        reset_i;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [31:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic        irq_o;
   integer      seed;                       // Random stream state
   int          cycle_cnt = 0;

   soc_top #(
      .SRAM_DEPTH ( MEM_WORDS ) )
   soc_top_i (
      .hclk_i   ( hclk_i   ),
      .reset_i  ( reset_i  ),
      .wb_cyc_i ( wb_cyc_i ),
      .wb_stb_i ( wb_stb_i ),
      .wb_we_i  ( wb_we_i  ),
      .wb_adr_i ( wb_adr_i ),
      .wb_dat_i ( wb_dat_i ),
      .wb_sel_i ( wb_sel_i ),
      .wb_dat_o ( wb_dat_o ),
      .wb_ack_o ( wb_ack_o ),
      .wb_err_o ( wb_err_o ),
      .irq_o    ( irq_o    ) );

   // 4 ns clock
   initial begin
      hclk_i = 1'b0;
      forever #2 hclk_i = ~hclk_i;
   end

   `include "tb_soc_tasks.svh"

   // Watchdog
   always @(posedge hclk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         abort_run("Simulation ran past the cycle limit without finishing");
      end
   end

   ////////////////////////////////////////////////////////////
   // Timer run up to the first compare match
   task automatic timer_match_case(input logic irq_en);
      logic [31:0] rnd;
      logic [31:0] rd;
      int          psc;
      int          cmp;
      int          bound;
      int          start;
      rnd   = $random(seed);
      psc   = int'(rnd[2:0]);                   // 0 to 7
      cmp   = 1 + (int'(rnd[6:3]) % 15);        // 1 to 15
      bound = (psc + 1) * (cmp + 1) + 4;        // Cycles until the match shows
      timer_write(soc_pkg::TMR_CTRL_OFS, 32'd0);
      timer_write(soc_pkg::TMR_PRESCALE_OFS, psc);
      timer_write(soc_pkg::TMR_COMPARE_OFS, cmp);
      timer_write(soc_pkg::TMR_COUNT_OFS, 32'd0);
      timer_write(soc_pkg::TMR_STATUS_OFS, 32'd1);   // Drop a stale pending flag
      timer_write(soc_pkg::TMR_CTRL_OFS, {30'd0, irq_en, 1'b1});
      start = cycle_cnt;
      if (irq_en) begin
         while (!irq_o) begin
            if (cycle_cnt - start > bound) begin
               abort_run("Timer interrupt did not rise within the compare period");
            end
            @(posedge hclk_i);
            #DRV_DLY;
         end
         timer_write(soc_pkg::TMR_CTRL_OFS, 32'h2);   // Stop count, keep irq enable
         timer_read(soc_pkg::TMR_STATUS_OFS, rd);
         check_value("wb_dat_o timer status", rd, 32'd1);
         timer_write(soc_pkg::TMR_STATUS_OFS, 32'd1);
         check_value("irq_o", irq_o, 1'b0);           // Two cycles after the request
         timer_read(soc_pkg::TMR_STATUS_OFS, rd);
         check_value("wb_dat_o timer status", rd, 32'd0);
      end else begin
         rd = 32'd0;
         while (!rd[0]) begin
            if (cycle_cnt - start > bound) begin
               abort_run("Timer pending flag did not set within the compare period");
            end
            timer_read(soc_pkg::TMR_STATUS_OFS, rd);
            check_value("irq_o", irq_o, 1'b0);        // Interrupt masked
         end
         timer_write(soc_pkg::TMR_CTRL_OFS, 32'd0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      logic [31:0] rnd;
      logic [31:0] wdat;
      logic [31:0] rd;
      logic [31:0] adr;
      logic        err;
      seed     = 32'hb659_a85e;
      reset_i  = 1'b1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      repeat (5) @(posedge hclk_i);
      #DRV_DLY;
      reset_i = 1'b0;

      // Reset state
      check_value("wb_ack_o", wb_ack_o, 1'b0);
      check_value("wb_err_o", wb_err_o, 1'b0);
      check_value("irq_o", irq_o, 1'b0);
      timer_read(soc_pkg::TMR_CTRL_OFS, rd);
      check_value("wb_dat_o timer ctrl", rd, 32'd0);
      timer_read(soc_pkg::TMR_COUNT_OFS, rd);
      check_value("wb_dat_o timer count", rd, 32'd0);
      timer_read(soc_pkg::TMR_STATUS_OFS, rd);
      check_value("wb_dat_o timer status", rd, 32'd0);

      // Known contents in every word first
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_write(i, fill_word(i), 4'hF);
      end

      // Random byte lane writes mixed with reads
      repeat (N_RAND) begin
         rnd  = $random(seed);
         wdat = $random(seed);
         if (rnd[31]) begin
            mem_check(int'(rnd[8:0]));
         end else begin
            mem_write(int'(rnd[8:0]), wdat, rnd[15:12]);
         end
      end

      // Unmapped accesses answer err and leave memory alone
      repeat (N_MISS) begin
         do begin
            adr = $random(seed);
         end while (in_window(adr));
         rnd = $random(seed);
         bus_access(rnd[0], adr, rnd, 4'hF, rd, err);
         check_value("wb_err_o", err, 1'b1);
         mem_check(int'(adr[10:2]));
      end

      // Timer register readback
      rnd = $random(seed);
      timer_write(soc_pkg::TMR_PRESCALE_OFS, rnd);
      timer_read(soc_pkg::TMR_PRESCALE_OFS, rd);
      check_value("wb_dat_o timer prescale", rd, rnd);
      rnd = $random(seed);
      timer_write(soc_pkg::TMR_COMPARE_OFS, rnd);
      timer_read(soc_pkg::TMR_COMPARE_OFS, rd);
      check_value("wb_dat_o timer compare", rd, rnd);
      do begin
         rnd = $random(seed);
      end while (rnd[3:0] < 4'd5);                   // Offsets 5 to 15 unused
      timer_write(rnd[3:0], 32'hFFFF_FFFF);
      timer_read(rnd[3:0], rd);
      check_value("wb_dat_o timer unused", rd, 32'd0);

      timer_match_case(1'b1);                        // Interrupt path
      timer_match_case(1'b0);                        // Masked, flag only

      $display("Test OK");
      $finish;
   end

endmodule

//--- verilog/soc_top.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Bus system top level
// Decoder, word memory and compare timer on one master port
////////////////////////////////////////////////////////////
module soc_top #(
   parameter int                         SRAM_DEPTH = 512,
   parameter logic [soc_pkg::ADDR_W-1:0] SRAM_BASE  = soc_pkg::SRAM_BASE_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] SRAM_MASK  = soc_pkg::SRAM_MASK_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] TIMER_BASE = soc_pkg::TIMER_BASE_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] TIMER_MASK = soc_pkg::TIMER_MASK_DEF
) (
   input  logic                       hclk_i,
   input  logic                       reset_i,
   // Master port
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [soc_pkg::ADDR_W-1:0] wb_adr_i,
   input  logic [soc_pkg::DATA_W-1:0] wb_dat_i,
   input  logic [soc_pkg::SEL_W-1:0]  wb_sel_i,
   output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   output logic                       irq_o              // Timer interrupt, line 0
);

   ////////////////////////////////////////////////////////////
   // Slave responses
   logic                       sram_stb;
   logic [soc_pkg::DATA_W-1:0] sram_dat;
   logic                       sram_ack;
   logic                       timer_stb;
   logic [soc_pkg::DATA_W-1:0] timer_dat;
   logic                       timer_ack;

   wb_addr_decoder #(
      .SRAM_BASE   ( SRAM_BASE  ),
      .SRAM_MASK   ( SRAM_MASK  ),
      .TIMER_BASE  ( TIMER_BASE ),
      .TIMER_MASK  ( TIMER_MASK ) )
   decoder_i (
      .hclk_i      ( hclk_i     ),
      .reset_i     ( reset_i    ),
      .wb_cyc_i    ( wb_cyc_i   ),
      .wb_stb_i    ( wb_stb_i   ),
      .wb_adr_i    ( wb_adr_i   ),
      .wb_dat_o    ( wb_dat_o   ),
      .wb_ack_o    ( wb_ack_o   ),
      .wb_err_o    ( wb_err_o   ),
      .sram_stb_o  ( sram_stb   ),
      .timer_stb_o ( timer_stb  ),
      .sram_dat_i  ( sram_dat   ),
      .sram_ack_i  ( sram_ack   ),
      .timer_dat_i ( timer_dat  ),
      .timer_ack_i ( timer_ack  ) );

   // Word memory, request lines shared with the timer
   wb_sram #(
      .SRAM_DEPTH ( SRAM_DEPTH ) )
   sram_i (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .cyc_i      ( wb_cyc_i   ),
      .stb_i      ( sram_stb   ),             // Private strobe
      .we_i       ( wb_we_i    ),
      .adr_i      ( wb_adr_i   ),
      .dat_i      ( wb_dat_i   ),
      .sel_i      ( wb_sel_i   ),
      .dat_o      ( sram_dat   ),
      .ack_o      ( sram_ack   ) );

   wb_timer timer_i (
      .hclk_i     ( hclk_i     ),
      .reset_i    ( reset_i    ),
      .cyc_i      ( wb_cyc_i   ),
      .stb_i      ( timer_stb  ),             // Private strobe
      .we_i       ( wb_we_i    ),
      .adr_i      ( wb_adr_i   ),
      .dat_i      ( wb_dat_i   ),
      .sel_i      ( wb_sel_i   ),
      .dat_o      ( timer_dat  ),
      .ack_o      ( timer_ack  ),
      .irq_o      ( irq_o      ) );           // Straight to the top

endmodule

//--- verilog/wb_timer.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Wishbone compare timer
// Prescaled counter, compare match, pending flag and irq
////////////////////////////////////////////////////////////
module wb_timer (
   input  logic                       hclk_i,
   input  logic                       reset_i,
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [soc_pkg::ADDR_W-1:0] adr_i,
   input  logic [soc_pkg::DATA_W-1:0] dat_i,
   input  logic [soc_pkg::SEL_W-1:0]  sel_i,
   output logic [soc_pkg::DATA_W-1:0] dat_o,
   output logic                       ack_o,
   output logic                       irq_o
);

   logic [3:0]                 ofs;          // Register word offset
   logic                       access;
   logic                       wr;
   logic                       ack_q;
   logic [soc_pkg::DATA_W-1:0] dat_q;
   logic [soc_pkg::DATA_W-1:0] rd_data;

   // Register file
   logic [1:0]                 ctrl_q;       // [0] enable, [1] irq enable
   logic [soc_pkg::DATA_W-1:0] prescale_q;
   logic [soc_pkg::DATA_W-1:0] count_q;
   logic [soc_pkg::DATA_W-1:0] compare_q;
   logic                       pending_q;    // Status bit 0
   logic [soc_pkg::DATA_W-1:0] psc_cnt_q;    // Prescale divider
   logic                       irq_q;

   logic tick;                               // Count advance
   logic match;                              // Count reached compare at an advance
   logic clr_pending;

   assign ofs    = adr_i[5:2];
   assign access = cyc_i & stb_i & ~ack_q;
   assign wr     = access & we_i;

   assign tick        = ctrl_q[0] & (psc_cnt_q == prescale_q);
   assign match       = tick & (count_q == compare_q);
   assign clr_pending = wr & (ofs == soc_pkg::TMR_STATUS_OFS) & sel_i[0] & dat_i[0];

   ////////////////////////////////////////////////////////////
   // Counter and registers
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         ctrl_q     <= '0;
         prescale_q <= '0;
         count_q    <= '0;
         compare_q  <= '0;
         pending_q  <= 1'b0;
         psc_cnt_q  <= '0;
         irq_q      <= 1'b0;
         ack_q      <= 1'b0;
      end else begin
         // Divider restarts on each advance and while disabled
         if (!ctrl_q[0] || tick) begin
            psc_cnt_q <= '0;
         end else begin
            psc_cnt_q <= psc_cnt_q + 1'b1;
         end

         if (match) begin
            count_q <= '0;                   // Wrap at compare
         end else if (tick) begin
            count_q <= count_q + 1'b1;
         end

         // Bus writes, taken at the acknowledging edge and over the counter
         if (wr) begin
            case (ofs)
               soc_pkg::TMR_CTRL_OFS: begin
                  if (sel_i[0]) begin
                     ctrl_q <= dat_i[1:0];
                  end
               end
               soc_pkg::TMR_PRESCALE_OFS:
                  prescale_q <= soc_pkg::wr_merge(prescale_q, dat_i, sel_i);
               soc_pkg::TMR_COUNT_OFS:
                  count_q <= soc_pkg::wr_merge(count_q, dat_i, sel_i);
               soc_pkg::TMR_COMPARE_OFS:
                  compare_q <= soc_pkg::wr_merge(compare_q, dat_i, sel_i);
               default: ;                    // Status handled below, rest ignored
            endcase
         end

         // Pending: a match in the same cycle beats the clear
         if (match) begin
            pending_q <= 1'b1;
         end else if (clr_pending) begin
            pending_q <= 1'b0;
         end

         irq_q <= pending_q & ctrl_q[1];     // Registered interrupt
         ack_q <= access;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read mux, registered with the ack
   always_comb begin
      rd_data = '0;
      case (ofs)
         soc_pkg::TMR_CTRL_OFS:     rd_data[1:0] = ctrl_q;
         soc_pkg::TMR_PRESCALE_OFS: rd_data      = prescale_q;
         soc_pkg::TMR_COUNT_OFS:    rd_data      = count_q;
         soc_pkg::TMR_COMPARE_OFS:  rd_data      = compare_q;
         soc_pkg::TMR_STATUS_OFS:   rd_data[0]   = pending_q;
         default:                   rd_data      = '0;   // Unused offsets
      endcase
   end

   always_ff @(posedge hclk_i) begin
      if (access) begin
         dat_q <= rd_data;
      end
   end

   assign dat_o = dat_q;
   assign ack_o = ack_q;
   assign irq_o = irq_q;

   // irq only with interrupt enable set the cycle before
   a_irq_enabled: assert property (@(posedge hclk_i) disable iff (reset_i)
      irq_q |-> $past(ctrl_q[1]))
      else $error("timer irq without interrupt enable");

   a_ack_pulse: assert property (@(posedge hclk_i) disable iff (reset_i)
      ack_q |=> !ack_q)
      else $error("timer ack longer than one cycle");

endmodule

//--- verilog/wb_sram.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Wishbone word memory with byte lane writes
////////////////////////////////////////////////////////////
module wb_sram #(
   parameter int SRAM_DEPTH = 512                    // Words
) (
   input  logic                       hclk_i,
   input  logic                       reset_i,
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [soc_pkg::ADDR_W-1:0] adr_i,
   input  logic [soc_pkg::DATA_W-1:0] dat_i,
   input  logic [soc_pkg::SEL_W-1:0]  sel_i,
   output logic [soc_pkg::DATA_W-1:0] dat_o,
   output logic                       ack_o
);

   localparam int IDX_W = $clog2(SRAM_DEPTH);

   logic [soc_pkg::DATA_W-1:0] mem [SRAM_DEPTH];     // Storage array
   logic [IDX_W-1:0]           idx;                  // Word index
   logic                       access;               // Acknowledging edge ahead
   logic                       ack_q;
   logic [soc_pkg::DATA_W-1:0] dat_q;

   // Word address, byte offset bits dropped
   assign idx    = adr_i[2 +: IDX_W];
   assign access = cyc_i & stb_i & ~ack_q;

   ////////////////////////////////////////////////////////////
   // Array access
   always_ff @(posedge hclk_i) begin
      if (access && we_i) begin
         for (int b = 0; b < soc_pkg::SEL_W; b++) begin
            if (sel_i[b]) begin
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];   // Only selected lanes
            end
         end
      end
      if (access) begin
         dat_q <= mem[idx];                          // Read data for the ack cycle
      end
   end

   // Handshake, one ack per request
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;                            // Self clears after one cycle
      end
   end

   assign dat_o = dat_q;
   assign ack_o = ack_q;

   // No ack without a request in the cycle before
   a_ack_needs_req: assert property (@(posedge hclk_i) disable iff (reset_i)
      ack_q |-> $past(cyc_i && stb_i))
      else $error("memory ack without request");

endmodule

//--- verilog/wb_addr_decoder.sv
`timescale 1ns/1ps
////////////////////////////////////////////////////////////
// Wishbone address decoder for one master, two slaves
// Base/mask select, response mux and error on unmapped
////////////////////////////////////////////////////////////
module wb_addr_decoder #(
   parameter logic [soc_pkg::ADDR_W-1:0] SRAM_BASE  = soc_pkg::SRAM_BASE_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] SRAM_MASK  = soc_pkg::SRAM_MASK_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] TIMER_BASE = soc_pkg::TIMER_BASE_DEF,
   parameter logic [soc_pkg::ADDR_W-1:0] TIMER_MASK = soc_pkg::TIMER_MASK_DEF
) (
   input  logic                       hclk_i,
   input  logic                       reset_i,
   // Master side
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic [soc_pkg::ADDR_W-1:0] wb_adr_i,
   output logic [soc_pkg::DATA_W-1:0] wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   // Slave side
   output logic                       sram_stb_o,
   output logic                       timer_stb_o,
   input  logic [soc_pkg::DATA_W-1:0] sram_dat_i,
   input  logic                       sram_ack_i,
   input  logic [soc_pkg::DATA_W-1:0] timer_dat_i,
   input  logic                       timer_ack_i
);

   logic req;          // Active request cycle
   logic sram_hit;
   logic timer_hit;
   logic miss;         // Address in no window
   logic sram_sel_q;   // Registered choice for the response mux
   logic timer_sel_q;
   logic err_q;

   ////////////////////////////////////////////////////////////
   // Window compare
   assign req       = wb_cyc_i & wb_stb_i;
   assign sram_hit  = (wb_adr_i & SRAM_MASK) == (SRAM_BASE & SRAM_MASK);
   assign timer_hit = ((wb_adr_i & TIMER_MASK) == (TIMER_BASE & TIMER_MASK))
                      & ~sram_hit;                   // Memory wins on overlap
   assign miss      = ~sram_hit & ~timer_hit;

   assign sram_stb_o  = wb_stb_i & sram_hit;         // Private strobes
   assign timer_stb_o = wb_stb_i & timer_hit;

   // Selection and error slave, one cycle like the real slaves
   always_ff @(posedge hclk_i) begin
      if (reset_i) begin
         sram_sel_q  <= 1'b0;
         timer_sel_q <= 1'b0;
         err_q       <= 1'b0;
      end else begin
         if (req) begin
            sram_sel_q  <= sram_hit;
            timer_sel_q <= timer_hit;
         end
         err_q <= req & miss & ~err_q;               // Drops after one cycle
      end
   end

   ////////////////////////////////////////////////////////////
   // Response mux
   always_comb begin
      wb_dat_o = '0;
      if (sram_sel_q) begin
         wb_dat_o = sram_dat_i;
      end else if (timer_sel_q) begin
         wb_dat_o = timer_dat_i;
      end
   end

   assign wb_ack_o = (sram_sel_q & sram_ack_i) | (timer_sel_q & timer_ack_i);
   assign wb_err_o = err_q;

   // Raw slave acks and decoder err must stay exclusive
   a_ack_err_excl: assert property (@(posedge hclk_i) disable iff (reset_i)
      !(wb_err_o && (sram_ack_i || timer_ack_i)))
      else $error("slave ack together with decoder err");

endmodule

//--- verilog/soc_pkg.sv
////////////////////////////////////////////////////////////
// System package for the Wishbone bus system
// Bus widths, default memory map and timer register map
////////////////////////////////////////////////////////////
package soc_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths
   parameter int ADDR_W = 32;                 // Byte address
   parameter int DATA_W = 32;                 // One bus word
   parameter int SEL_W  = DATA_W / 8;         // Byte lanes

   ////////////////////////////////////////////////////////////
   // Default memory map, base/mask pairs
   // Memory window, 2 KB at the bottom of the map
   parameter logic [ADDR_W-1:0] SRAM_BASE_DEF  = 32'h0000_0000;
   parameter logic [ADDR_W-1:0] SRAM_MASK_DEF  = 32'hFFFF_F800;
   // Timer window, 64 bytes in the peripheral space
   parameter logic [ADDR_W-1:0] TIMER_BASE_DEF = 32'h4000_0400;
   parameter logic [ADDR_W-1:0] TIMER_MASK_DEF = 32'hFFFF_FFC0;

   ////////////////////////////////////////////////////////////
   // Timer register word offsets
   parameter logic [3:0] TMR_CTRL_OFS     = 4'd0;   // [0] enable, [1] irq enable
   parameter logic [3:0] TMR_PRESCALE_OFS = 4'd1;   // Advance every prescale+1 cycles
   parameter logic [3:0] TMR_COUNT_OFS    = 4'd2;   // Current count, read/write
   parameter logic [3:0] TMR_COMPARE_OFS  = 4'd3;   // Wrap value
   parameter logic [3:0] TMR_STATUS_OFS   = 4'd4;   // [0] pending, write 1 to clear

   // Byte lane merge of a write into an existing word
   // Lanes without a select bit keep the old byte
   function automatic logic [DATA_W-1:0] wr_merge(
      input logic [DATA_W-1:0] old_d,
      input logic [DATA_W-1:0] new_d,
      input logic [SEL_W-1:0]  sel
   );
      logic [DATA_W-1:0] res;
      res = old_d;
      for (int b = 0; b < SEL_W; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_d[8*b +: 8];  // Selected lane takes new byte
         end
      end
      return res;
   endfunction

endpackage
